// File: rtl/scope_pkg.sv
`default_nettype none

package scope_pkg;

    localparam int n_channels     = 6;
    localparam int sample_width   = 24;
    localparam int dest_width     = 8;
    localparam int offset_width   = 3;
    localparam int div_width      = 16;
    localparam int len_width      = 10;
    localparam int reg_addr_width = 3;

    // Register map of the flat configuration port
    localparam int reg_chan_sel    = 0;
    localparam int reg_window_base = 1;
    localparam int reg_timebase    = 2;
    localparam int reg_trig_chan   = 3;
    localparam int reg_trig_level  = 4;
    localparam int reg_capture_len = 5;
    localparam int reg_control     = 6;

    typedef logic [sample_width-1:0]   sample_t;
    typedef logic [dest_width-1:0]     dest_t;
    typedef logic [offset_width-1:0]   chan_offset_t;
    typedef logic [2:0]                chan_idx_t;
    typedef logic [div_width-1:0]      div_t;
    typedef logic [len_width-1:0]      cap_len_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [31:0]               reg_data_t;

    // Divider value after reset, giving one tick every 100 cycles
    localparam div_t div_reset = 16'd99;

    // One captured frame, channel 0 in the low bits
    typedef sample_t [n_channels-1:0] frame_t;

    typedef struct packed {
        chan_offset_t [n_channels-1:0] offsets;
        dest_t                         window_base;
        div_t                          divider;
        logic                          ext_timebase;
        chan_idx_t                     trig_chan;
        sample_t                       trig_level;
        cap_len_t                      capture_len;
    } scope_cfg_t;

    typedef enum logic [1:0] {
        idle      = 2'd0,
        armed     = 2'd1,
        capturing = 2'd2,
        done      = 2'd3
    } capture_state_t;

endpackage

`default_nettype wire

// File: rtl/scope_regs.sv
`timescale 1ns/1ns
`default_nettype none

module scope_regs (
    input  wire                        clock,
    input  wire                        rst_n,
    input  wire scope_pkg::reg_addr_t  reg_addr,
    input  wire scope_pkg::reg_data_t  reg_wdata,
    input  wire                        reg_write,
    input  wire scope_pkg::capture_state_t state,
    output scope_pkg::reg_data_t       reg_rdata,
    output scope_pkg::scope_cfg_t      cfg,
    output logic                       arm
);

    // Configuration storage, one field per register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cfg         <= '0;
            cfg.divider <= scope_pkg::div_reset;
        end else if (reg_write) begin
            case (reg_addr)
                scope_pkg::reg_chan_sel: begin
                    for (int i = 0; i < scope_pkg::n_channels; i++) begin
                        cfg.offsets[i] <= reg_wdata[4*i +: scope_pkg::offset_width];
                    end
                end
                scope_pkg::reg_window_base: begin
                    cfg.window_base <= reg_wdata[scope_pkg::dest_width-1:0];
                end
                scope_pkg::reg_timebase: begin
                    cfg.divider      <= reg_wdata[scope_pkg::div_width-1:0];
                    cfg.ext_timebase <= reg_wdata[16];
                end
                scope_pkg::reg_trig_chan: begin
                    cfg.trig_chan <= reg_wdata[2:0];
                end
                scope_pkg::reg_trig_level: begin
                    cfg.trig_level <= reg_wdata[scope_pkg::sample_width-1:0];
                end
                scope_pkg::reg_capture_len: begin
                    cfg.capture_len <= reg_wdata[scope_pkg::len_width-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // Arm is a single cycle strobe from a control write with bit 0 set
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            arm <= 1'b0;
        end else begin
            arm <= reg_write && (reg_addr == scope_pkg::reg_addr_t'(scope_pkg::reg_control))
                   && reg_wdata[0];
        end
    end

    // Read words keep the unused bits at zero
    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            scope_pkg::reg_chan_sel: begin
                for (int i = 0; i < scope_pkg::n_channels; i++) begin
                    reg_rdata[4*i +: scope_pkg::offset_width] = cfg.offsets[i];
                end
            end
            scope_pkg::reg_window_base: reg_rdata[scope_pkg::dest_width-1:0] = cfg.window_base;
            scope_pkg::reg_timebase: begin
                reg_rdata[scope_pkg::div_width-1:0] = cfg.divider;
                reg_rdata[16]                       = cfg.ext_timebase;
            end
            scope_pkg::reg_trig_chan:   reg_rdata[2:0] = cfg.trig_chan;
            scope_pkg::reg_trig_level:  reg_rdata[scope_pkg::sample_width-1:0] = cfg.trig_level;
            scope_pkg::reg_capture_len: reg_rdata[scope_pkg::len_width-1:0] = cfg.capture_len;
            scope_pkg::reg_control:     reg_rdata[1:0] = state;
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/channel_demux.sv
`timescale 1ns/1ns
`default_nettype none

module channel_demux (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire scope_pkg::scope_cfg_t  cfg,
    input  wire                         in_valid,
    input  wire scope_pkg::dest_t       in_dest,
    input  wire scope_pkg::sample_t     in_data,
    output scope_pkg::frame_t           held
);

    scope_pkg::dest_t sel_dest [scope_pkg::n_channels];

    // The sum is truncated to the tag width, so a base near 255 wraps to low tags
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < scope_pkg::n_channels; i++) begin
                sel_dest[i] <= '0;
            end
        end else begin
            for (int i = 0; i < scope_pkg::n_channels; i++) begin
                sel_dest[i] <= cfg.window_base + scope_pkg::dest_t'(cfg.offsets[i]);
            end
        end
    end

    // Several channels may select the same tag and then all update together
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            held <= '0;
        end else if (in_valid) begin
            for (int i = 0; i < scope_pkg::n_channels; i++) begin
                if (in_dest == sel_dest[i]) begin
                    held[i] <= in_data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/sample_timebase.sv
`timescale 1ns/1ns
`default_nettype none

module sample_timebase (
    input  wire                        clock,
    input  wire                        rst_n,
    input  wire scope_pkg::scope_cfg_t cfg,
    input  wire                        sampling_clock,
    output logic                       tick
);

    scope_pkg::div_t count;
    scope_pkg::div_t div_q;
    logic            ext_q;
    logic            restart;
    logic [1:0]      sync;
    logic            sync_prev;
    logic            ext_edge;

    // Any change of divider or mode starts a fresh period
    assign restart  = (cfg.divider != div_q) || (cfg.ext_timebase != ext_q);
    assign ext_edge = sync[1] && !sync_prev;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count     <= '0;
            div_q     <= '0;
            ext_q     <= 1'b0;
            sync      <= '0;
            sync_prev <= 1'b0;
            tick      <= 1'b0;
        end else begin
            div_q     <= cfg.divider;
            ext_q     <= cfg.ext_timebase;
            // sampling_clock is asynchronous to clock
            sync      <= {sync[0], sampling_clock};
            sync_prev <= sync[1];
            if (restart || (count == cfg.divider)) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            if (cfg.ext_timebase) begin
                tick <= ext_edge;
            end else begin
                tick <= !restart && (count == cfg.divider);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/capture_unit.sv
`timescale 1ns/1ns
`default_nettype none

module capture_unit (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire scope_pkg::scope_cfg_t   cfg,
    input  wire scope_pkg::frame_t       held,
    input  wire                          tick,
    input  wire                          arm,
    input  wire                          dma_done,
    output scope_pkg::capture_state_t    state,
    output logic                         frame_valid,
    output logic                         frame_last,
    output logic                         trigger,
    output logic                         done,
    output scope_pkg::frame_t            frame_data
);

    scope_pkg::sample_t  cur_val;
    scope_pkg::sample_t  prev_val;
    logic                prev_ok;
    logic                crossing;
    scope_pkg::cap_len_t count;
    scope_pkg::cap_len_t next_count;
    scope_pkg::cap_len_t len_eff;

    // Channel numbers past the last channel watch a constant zero
    assign cur_val = (cfg.trig_chan < scope_pkg::chan_idx_t'(scope_pkg::n_channels)) ?
                     held[cfg.trig_chan] : '0;

    assign crossing   = prev_ok && (prev_val <= cfg.trig_level) && (cur_val > cfg.trig_level);
    assign len_eff    = (cfg.capture_len == '0) ? scope_pkg::cap_len_t'(1) : cfg.capture_len;
    assign next_count = count + 1'b1;
    assign done       = (state == scope_pkg::done);

    // Frame payload and the previous trigger sample follow every tick
    always_ff @(posedge clock) begin
        if (tick) begin
            frame_data <= held;
            prev_val   <= cur_val;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state       <= scope_pkg::idle;
            prev_ok     <= 1'b0;
            count       <= '0;
            frame_valid <= 1'b0;
            frame_last  <= 1'b0;
            trigger     <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            frame_last  <= 1'b0;
            trigger     <= 1'b0;
            case (state)
                scope_pkg::idle: begin
                    if (arm) begin
                        state   <= scope_pkg::armed;
                        prev_ok <= 1'b0;
                    end
                end
                scope_pkg::armed: begin
                    if (tick) begin
                        // The first tick after arming only fills prev_val
                        prev_ok <= 1'b1;
                        if (crossing) begin
                            frame_valid <= 1'b1;
                            trigger     <= 1'b1;
                            count       <= scope_pkg::cap_len_t'(1);
                            if (len_eff == scope_pkg::cap_len_t'(1)) begin
                                frame_last <= 1'b1;
                                state      <= scope_pkg::done;
                            end else begin
                                state <= scope_pkg::capturing;
                            end
                        end
                    end
                end
                scope_pkg::capturing: begin
                    if (tick) begin
                        frame_valid <= 1'b1;
                        count       <= next_count;
                        if (next_count == len_eff) begin
                            frame_last <= 1'b1;
                            state      <= scope_pkg::done;
                        end
                    end
                end
                scope_pkg::done: begin
                    // Stay here until the DMA side has taken the frames
                    if (arm || dma_done) begin
                        state   <= scope_pkg::armed;
                        prev_ok <= 1'b0;
                    end
                end
                default: state <= scope_pkg::idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/scope_stream.sv
`timescale 1ns/1ns
`default_nettype none

module scope_stream (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire                         sampling_clock,
    input  wire                         dma_done,
    input  wire                         in_valid,
    input  wire scope_pkg::dest_t       in_dest,
    input  wire scope_pkg::sample_t     in_data,
    input  wire scope_pkg::reg_addr_t   reg_addr,
    input  wire scope_pkg::reg_data_t   reg_wdata,
    input  wire                         reg_write,
    output scope_pkg::reg_data_t        reg_rdata,
    output logic                        frame_valid,
    output scope_pkg::frame_t           frame_data,
    output logic                        frame_last,
    output logic                        trigger,
    output logic                        done
);

    scope_pkg::scope_cfg_t     cfg;
    scope_pkg::capture_state_t state;
    scope_pkg::frame_t         held;
    logic                      arm;
    logic                      tick;

    scope_regs i_regs (
        .clock     (clock),
        .rst_n     (rst_n),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_write (reg_write),
        .state     (state),
        .reg_rdata (reg_rdata),
        .cfg       (cfg),
        .arm       (arm)
    );

    channel_demux i_demux (
        .clock    (clock),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .in_valid (in_valid),
        .in_dest  (in_dest),
        .in_data  (in_data),
        .held     (held)
    );

    sample_timebase i_timebase (
        .clock          (clock),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .sampling_clock (sampling_clock),
        .tick           (tick)
    );

    // Frames leave one cycle after the tick that sampled them
    capture_unit i_capture (
        .clock       (clock),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .held        (held),
        .tick        (tick),
        .arm         (arm),
        .dma_done    (dma_done),
        .state       (state),
        .frame_valid (frame_valid),
        .frame_last  (frame_last),
        .trigger     (trigger),
        .done        (done),
        .frame_data  (frame_data)
    );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    // 8 ns period, reset released shortly after the second rising edge
    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clock);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_frame_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_frame_checker (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire                     frame_valid,
    input  wire scope_pkg::frame_t  frame_data,
    input  wire                     frame_last,
    input  wire                     trigger,
    input  wire                     done,
    input  wire scope_pkg::frame_t  exp_frame,
    input  wire [10:0]              exp_len,
    input  wire [95:0]              test_name,
    input  wire                     test_start,
    input  wire                     test_end,
    input  wire                     status_fail,
    output int                      pass_count,
    output int                      fail_count
);

    int seen;
    int errors;

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            seen       = 0;
            errors     = 0;
            pass_count = 0;
            fail_count = 0;
        end else if (test_start) begin
            seen   = 0;
            errors = 0;
        end else begin
            if (frame_valid) begin
                if (seen >= int'(exp_len)) begin
                    $display("%0s: a frame arrived beyond the capture length", test_name);
                    errors++;
                end else begin
                    if (frame_data !== exp_frame) begin
                        $display("** Error %0s frame %0d expected %h actual %h",
                                 test_name, seen, exp_frame, frame_data);
                        errors++;
                    end
                    if (trigger !== (seen == 0)) begin
                        $display("** Error %0s trigger on frame %0d expected %0d actual %0d",
                                 test_name, seen, (seen == 0), trigger);
                        errors++;
                    end
                    if (frame_last !== (seen == int'(exp_len) - 1)) begin
                        $display("** Error %0s last flag on frame %0d expected %0d actual %0d",
                                 test_name, seen, (seen == int'(exp_len) - 1), frame_last);
                        errors++;
                    end
                end
                seen++;
            end else if (trigger) begin
                $display("%0s: trigger pulsed without a frame", test_name);
                errors++;
            end
            if (test_end) begin
                if (seen < int'(exp_len)) begin
                    $display("%0s: only %0d of %0d frames arrived", test_name, seen, exp_len);
                    errors++;
                end
                if (!done) begin
                    $display("%0s: done is low after the capture", test_name);
                    errors++;
                end
                if (status_fail) errors++;
                if (errors == 0) begin
                    $display("%0s: passed with %0d frames", test_name, seen);
                    pass_count++;
                end else begin
                    $display("%0s: failed with %0d errors", test_name, errors);
                    fail_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_scope_stream.sv
`timescale 1ns/1ns
`default_nettype none

module tb_scope_stream;

    localparam int div_val   = 15;
    localparam int edge_half = 8;
    // Tick budget covers the four captures with their lead-in and drain
    localparam int total_ticks = 58;
    localparam int watchdog_ns = total_ticks * (div_val + 1) * 8 + 4000;
    localparam scope_pkg::sample_t level = 24'h80_0000;

    logic clock;
    logic rst_n;
    logic sampling_clock;
    logic dma_done;
    logic in_valid;
    scope_pkg::dest_t in_dest;
    scope_pkg::sample_t in_data;
    scope_pkg::reg_addr_t reg_addr;
    scope_pkg::reg_data_t reg_wdata;
    scope_pkg::reg_data_t reg_rdata;
    logic reg_write;
    logic frame_valid;
    scope_pkg::frame_t frame_data;
    logic frame_last;
    logic trigger;
    logic done;

    scope_pkg::frame_t exp_frame;
    logic [10:0] exp_len;
    logic [95:0] test_name;
    logic test_start;
    logic test_end;
    logic status_fail;
    int chk_pass;
    int chk_fail;
    int top_pass;
    int top_fail;
    integer seed;

    // Latest sample per destination tag
    scope_pkg::sample_t model_mem [256];
    scope_pkg::dest_t cur_base;
    scope_pkg::chan_offset_t cur_offs [scope_pkg::n_channels];

    tb_clock_gen i_clock_gen (.clock(clock), .rst_n(rst_n));

    scope_stream i_scope_stream (
        .clock(clock), .rst_n(rst_n), .sampling_clock(sampling_clock),
        .dma_done(dma_done), .in_valid(in_valid), .in_dest(in_dest), .in_data(in_data),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_write(reg_write),
        .reg_rdata(reg_rdata), .frame_valid(frame_valid), .frame_data(frame_data),
        .frame_last(frame_last), .trigger(trigger), .done(done)
    );

    tb_frame_checker i_frame_checker (
        .clock(clock), .rst_n(rst_n), .frame_valid(frame_valid), .frame_data(frame_data),
        .frame_last(frame_last), .trigger(trigger), .done(done), .exp_frame(exp_frame),
        .exp_len(exp_len), .test_name(test_name), .test_start(test_start),
        .test_end(test_end), .status_fail(status_fail),
        .pass_count(chk_pass), .fail_count(chk_fail)
    );

    function automatic scope_pkg::dest_t sel_dest_of(input scope_pkg::dest_t base,
                                                     input scope_pkg::chan_offset_t off);
        return scope_pkg::dest_t'(base + scope_pkg::dest_t'(off));
    endfunction

    function automatic scope_pkg::frame_t expected_frame();
        scope_pkg::frame_t f;
        for (int i = 0; i < scope_pkg::n_channels; i++) begin
            f[i] = model_mem[sel_dest_of(cur_base, cur_offs[i])];
        end
        return f;
    endfunction

    function automatic scope_pkg::reg_data_t field_mask(input int addr);
        case (addr)
            scope_pkg::reg_chan_sel:    return 32'h0077_7777;
            scope_pkg::reg_window_base: return 32'h0000_00ff;
            scope_pkg::reg_timebase:    return 32'h0001_ffff;
            scope_pkg::reg_trig_chan:   return 32'h0000_0007;
            scope_pkg::reg_trig_level:  return 32'h00ff_ffff;
            scope_pkg::reg_capture_len: return 32'h0000_03ff;
            default:                    return 32'h0000_0000;
        endcase
    endfunction

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic reg_wr(input int addr, input scope_pkg::reg_data_t data);
        reg_addr  = scope_pkg::reg_addr_t'(addr);
        reg_wdata = data;
        reg_write = 1'b1;
        step();
        reg_write = 1'b0;
    endtask

    task automatic reg_rd(input int addr, output scope_pkg::reg_data_t data);
        reg_addr = scope_pkg::reg_addr_t'(addr);
        #2;
        data = reg_rdata;
    endtask

    task automatic send(input scope_pkg::dest_t dest, input scope_pkg::sample_t data);
        in_valid = 1'b1;
        in_dest  = dest;
        in_data  = data;
        model_mem[dest] = data;
        step();
        in_valid = 1'b0;
    endtask

    // One tick is either a divider period or one full sampling_clock cycle
    task automatic tick_wait(input logic ext, input int n);
        for (int k = 0; k < n; k++) begin
            if (ext) begin
                sampling_clock = 1'b1;
                repeat (edge_half) step();
                sampling_clock = 1'b0;
                repeat (edge_half) step();
            end else begin
                repeat (div_val + 1) step();
            end
        end
    endtask

    task automatic check_status(input int expected);
        scope_pkg::reg_data_t r;
        reg_rd(scope_pkg::reg_control, r);
        if (r !== scope_pkg::reg_data_t'(expected)) begin
            $display("** Error %0s status expected %0d actual %0d", test_name, expected, r);
            status_fail = 1'b1;
        end
    endtask

    task automatic run_readback();
        scope_pkg::reg_data_t w;
        scope_pkg::reg_data_t r;
        int errors;
        errors    = 0;
        test_name = "readback";
        reg_rd(scope_pkg::reg_control, r);
        if (r !== 32'd0) begin
            $display("** Error readback control expected 0 actual %0d", r);
            errors++;
        end
        reg_rd(scope_pkg::reg_timebase, r);
        if (r !== 32'd99) begin
            $display("** Error readback timebase expected 99 actual %0d", r);
            errors++;
        end
        for (int a = 0; a < scope_pkg::reg_control; a++) begin
            w = $random(seed);
            reg_wr(a, w);
            reg_rd(a, r);
            if (r !== (w & field_mask(a))) begin
                $display("** Error readback reg %0d expected %h actual %h",
                         a, w & field_mask(a), r);
                errors++;
            end
        end
        if (errors == 0) begin
            $display("readback: passed");
            top_pass++;
        end else begin
            $display("readback: failed with %0d errors", errors);
            top_fail++;
        end
    endtask

    task automatic run_capture(input logic [95:0] name, input scope_pkg::dest_t base,
                               input scope_pkg::reg_data_t sel_word,
                               input scope_pkg::chan_idx_t trig,
                               input scope_pkg::cap_len_t len, input logic ext,
                               input logic first);
        scope_pkg::dest_t trig_dest;
        scope_pkg::dest_t d;
        scope_pkg::sample_t v;
        int n_exp;
        int edges;
        test_name   = name;
        status_fail = 1'b0;
        n_exp       = (len == '0) ? 1 : int'(len);
        exp_len     = 11'(n_exp);
        cur_base    = base;
        for (int i = 0; i < scope_pkg::n_channels; i++) begin
            cur_offs[i] = sel_word[4*i +: 3];
        end
        test_start = 1'b1;
        step();
        test_start = 1'b0;
        reg_wr(scope_pkg::reg_chan_sel, sel_word);
        reg_wr(scope_pkg::reg_window_base, 32'(base));
        reg_wr(scope_pkg::reg_timebase, {15'd0, ext, 16'(div_val)});
        reg_wr(scope_pkg::reg_trig_chan, 32'(trig));
        reg_wr(scope_pkg::reg_trig_level, 32'(level));
        reg_wr(scope_pkg::reg_capture_len, 32'(len));
        step();
        trig_dest = sel_dest_of(base, cur_offs[trig]);
        // The trigger channel is already above the level when the unit arms
        v = scope_pkg::sample_t'($random(seed));
        v[23] = 1'b1;
        send(trig_dest, v);
        if (first) begin
            reg_wr(scope_pkg::reg_control, 32'd1);
        end else begin
            dma_done = 1'b1;
            step();
            dma_done = 1'b0;
        end
        step();
        check_status(scope_pkg::armed);
        // A level that stays above must not start a capture
        tick_wait(ext, 3);
        v = scope_pkg::sample_t'($random(seed));
        v[23] = 1'b0;
        send(trig_dest, v);
        // One tick records the low value ahead of the crossing
        tick_wait(ext, 1);
        for (int i = 0; i < scope_pkg::n_channels; i++) begin
            d = sel_dest_of(base, cur_offs[i]);
            if (d != trig_dest) send(d, scope_pkg::sample_t'($random(seed)));
        end
        for (int i = 0; i < 12; i++) begin
            d = scope_pkg::dest_t'(base + scope_pkg::dest_t'($random(seed) & 7));
            if (d == trig_dest) d = d ^ 8'h80;
            send(d, scope_pkg::sample_t'($random(seed)));
        end
        v = scope_pkg::sample_t'($random(seed));
        v[23] = 1'b1;
        model_mem[trig_dest] = v;
        exp_frame = expected_frame();
        send(trig_dest, v);
        edges = 0;
        for (int i = 0; i < n_exp + 6 && !done; i++) begin
            tick_wait(ext, 1);
            edges++;
        end
        // Each sampling_clock edge from the crossing on gives exactly one frame
        if (ext && edges != n_exp) begin
            $display("** Error %0s sampling_clock edges expected %0d actual %0d",
                     test_name, n_exp, edges);
            status_fail = 1'b1;
        end
        step();
        step();
        check_status(scope_pkg::done);
        test_end = 1'b1;
        step();
        test_end = 1'b0;
        step();
    endtask

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed           = 32'hc325_6abe;
        sampling_clock = 1'b0;
        dma_done       = 1'b0;
        in_valid       = 1'b0;
        in_dest        = '0;
        in_data        = '0;
        reg_addr       = '0;
        reg_wdata      = '0;
        reg_write      = 1'b0;
        exp_frame      = '0;
        exp_len        = '0;
        test_name      = '0;
        test_start     = 1'b0;
        test_end       = 1'b0;
        status_fail    = 1'b0;
        top_pass       = 0;
        top_fail       = 0;
        for (int i = 0; i < 256; i++) model_mem[i] = '0;
        @(posedge rst_n);
        step();
        run_readback();
        // Base near the top of the tag range wraps, channels 2 and 3 share a tag
        run_capture("extract", 8'hfd, 32'h0075_3310, 3'd0, 10'd4, 1'b0, 1'b1);
        run_capture("trigger", 8'h40, 32'h0046_1202, 3'd4, 10'd2, 1'b0, 1'b0);
        run_capture("length", 8'h80, 32'h0012_3456, 3'd1, 10'd0, 1'b0, 1'b0);
        run_capture("ext_rearm", 8'h10, 32'h0070_5321, 3'd5, 10'd3, 1'b1, 1'b0);
        repeat (4) step();
        $display("tests passed %0d failed %0d", top_pass + chk_pass, top_fail + chk_fail);
        if (top_fail + chk_fail == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
rtl/scope_pkg.sv
rtl/scope_regs.sv
rtl/channel_demux.sv
rtl/sample_timebase.sv
rtl/capture_unit.sv
rtl/scope_stream.sv
dv/tb_clock_gen.sv
dv/tb_frame_checker.sv
dv/tb_scope_stream.sv

// File: run.sh
#!/bin/bash
# Build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f files.f --top-module tb_scope_stream -o sim_scope \
    && ./obj_dir/sim_scope > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
